// File: run_sim.sh
#!/usr/bin/env bash
# build and run the affine stream testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f verilog.f \
  --top-module tb_affine_stream -o tb_affine_stream

./obj_dir/tb_affine_stream > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi

echo "simulation finished without failures"

// File: src/affine_defs.svh
`ifndef AFFINE_DEFS_SVH
`define AFFINE_DEFS_SVH

// ----------------------------------------
// stream geometry
// ----------------------------------------
`define AFF_LANE_W 16  // bits per stream lane
`define AFF_LANES  4   // lanes per input beat
`define AFF_ROWS   3   // matrix rows, output lanes

// ----------------------------------------
// arithmetic
// ----------------------------------------
`define AFF_ACC_W  32  // row sum wraps here
`define AFF_FRAC   16  // coefficient fraction bits

`endif

// File: src/affine_mac.sv
`timescale 1ns/1ns
`include "affine_defs.svh"

module affine_mac (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  // from the loader
  input  logic                                   vec_valid,
  input  affine_pkg::beat_t                      vec,
  input  logic                                   vec_last,
  input  affine_pkg::coef_row_t [`AFF_ROWS-1:0]  coef,
  output logic                                   advance,

  // output stream
  output affine_pkg::result_t                    m_tdata,
  output logic                                   m_tvalid,
  output logic                                   m_tlast,
  input  logic                                   m_tready
);

  localparam int PROD_W = 2 * `AFF_LANE_W;  // full signed product
  localparam int RES_LO = `AFF_FRAC - `AFF_LANE_W;

  affine_pkg::lane_t           lane   [`AFF_LANES];
  logic signed [PROD_W-1:0]    prod   [`AFF_ROWS][`AFF_LANES];
  logic signed [`AFF_ACC_W-1:0] sum_d [`AFF_ROWS];
  logic signed [`AFF_ACC_W-1:0] sum_q [`AFF_ROWS];

  logic s1_valid;
  logic s1_last;
  logic s2_valid;
  logic s2_last;

  // one enable for the whole pipe, empty slot or sink ready
  assign advance = ~m_tvalid | m_tready;

  // vector lanes in coefficient column order
  assign lane[0] = vec.vec.x;
  assign lane[1] = vec.vec.y;
  assign lane[2] = vec.vec.z;
  assign lane[3] = vec.vec.w;

  // ----------------------------------------
  // stage 1, products
  // ----------------------------------------
  // bank is sampled here, so a later reload cannot reach this vector
  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int r = 0; r < `AFF_ROWS; r++) begin
        for (int c = 0; c < `AFF_LANES; c++) begin
          prod[r][c] <= $signed(coef[r][c]) * $signed(lane[c]);
        end
      end
    end
  end

  // ----------------------------------------
  // stage 2, row sums
  // ----------------------------------------
  always_comb begin
    for (int r = 0; r < `AFF_ROWS; r++) begin
      sum_d[r] = '0;
      for (int c = 0; c < `AFF_LANES; c++) begin
        sum_d[r] = sum_d[r] + `AFF_ACC_W'(prod[r][c]);  // wraps
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      sum_q <= sum_d;
    end
  end

  // ----------------------------------------
  // stage 3, output register
  // ----------------------------------------
  // vector lanes are q0, so the sum is already q16
  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int r = 0; r < `AFF_ROWS; r++) begin
        m_tdata[r] <= sum_q[r][RES_LO +: `AFF_LANE_W];
      end
    end
  end

  // ----------------------------------------
  // valid and last tracking
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else if (advance) begin
      s1_valid <= vec_valid;
      s1_last  <= vec_last & vec_valid;  // only a real vector ends a frame
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
      m_tvalid <= s2_valid;
      m_tlast  <= s2_last;
    end
  end

endmodule

// File: src/affine_pkg.sv
`include "affine_defs.svh"

package affine_pkg;

  // signed q16 matrix coefficient
  typedef logic signed [`AFF_LANE_W-1:0] coef_t;

  // signed integer vector component
  typedef logic signed [`AFF_LANE_W-1:0] lane_t;

  // one matrix row, lane 0 in the low bits
  typedef coef_t [`AFF_LANES-1:0] coef_row_t;

  // one input word, either a matrix row or a vector
  typedef union packed {
    coef_row_t coef;  // matrix beat
    struct packed {
      lane_t w;
      lane_t z;
      lane_t y;
      lane_t x;       // low lane
    } vec;            // vector beat
  } beat_t;

  // transformed vector, x in the low lane
  typedef coef_t [`AFF_ROWS-1:0] result_t;

endpackage

// File: src/affine_stream_top.sv
`timescale 1ns/1ns
`include "affine_defs.svh"

module affine_stream_top (
  input  logic                 aclk,
  input  logic                 aresetn,

  // input stream, matrix rows then vectors
  input  affine_pkg::beat_t    s_tdata,
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  logic                 s_tlast,

  // output stream, one beat per vector
  output affine_pkg::result_t  m_tdata,
  output logic                 m_tvalid,
  input  logic                 m_tready,
  output logic                 m_tlast
);

  logic                                   advance;
  logic                                   vec_valid;
  affine_pkg::beat_t                      vec;
  logic                                   vec_last;
  affine_pkg::coef_row_t [`AFF_ROWS-1:0]  coef;

  // ----------------------------------------
  // beat sequencer
  // ----------------------------------------
  frame_loader u_loader (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tlast   (s_tlast),
    .s_tready  (s_tready),
    .advance   (advance),
    .vec_valid (vec_valid),
    .vec       (vec),
    .vec_last  (vec_last),
    .coef      (coef)
  );

  // ----------------------------------------
  // multiply-accumulate pipe
  // ----------------------------------------
  affine_mac u_mac (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .vec_valid (vec_valid),
    .vec       (vec),
    .vec_last  (vec_last),
    .coef      (coef),
    .advance   (advance),      // back-pressure to the loader
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tlast   (m_tlast),
    .m_tready  (m_tready)
  );

endmodule

// File: src/frame_loader.sv
`timescale 1ns/1ns
`include "affine_defs.svh"

module frame_loader (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  // input stream
  input  affine_pkg::beat_t                      s_tdata,
  input  logic                                   s_tvalid,
  input  logic                                   s_tlast,
  output logic                                   s_tready,

  // towards the mac pipe
  input  logic                                   advance,
  output logic                                   vec_valid,
  output affine_pkg::beat_t                      vec,
  output logic                                   vec_last,
  output affine_pkg::coef_row_t [`AFF_ROWS-1:0]  coef
);

  typedef enum logic {
    ST_LOAD,    // taking matrix rows
    ST_STREAM   // taking vectors
  } state_t;

  localparam logic [1:0] LAST_ROW = 2'(`AFF_ROWS - 1);

  state_t     state;
  logic [1:0] row;      // next matrix row to write
  logic       accept;   // beat handshake this cycle

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  // the pipe decides when anything moves, in both states
  assign s_tready = advance;
  assign accept   = s_tvalid & advance;

  // ----------------------------------------
  // frame state
  // ----------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state <= ST_LOAD;
      row   <= 2'd0;
    end else if (accept) begin
      case (state)
        ST_LOAD: begin
          if (row == LAST_ROW) begin
            state <= ST_STREAM;   // matrix complete
            row   <= 2'd0;
          end else begin
            row <= row + 2'd1;
          end
        end
        ST_STREAM: begin
          if (s_tlast) begin
            state <= ST_LOAD;     // frame done, reload
          end
        end
        default: begin
          state <= ST_LOAD;
        end
      endcase
    end
  end

  // ----------------------------------------
  // coefficient bank
  // ----------------------------------------
  // s_tlast is ignored on matrix beats
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      coef <= '0;
    end else if (accept && state == ST_LOAD) begin
      coef[row] <= s_tdata.coef;  // row view of the beat
    end
  end

  // ----------------------------------------
  // vector steering
  // ----------------------------------------
  assign vec_valid = accept & (state == ST_STREAM);
  assign vec       = s_tdata;   // mac reads the vec view
  assign vec_last  = s_tlast;

endmodule

// File: testbench/tb_affine_stream.sv
`timescale 1ns/1ns
`include "affine_defs.svh"

module tb_affine_stream;

  localparam int          N_FRAMES    = 40;
  localparam int          MAX_VECS    = 8;
  localparam int          CYCLE_LIMIT = 6000;  // 40 x 11 beats at ~4 cycles, plus slack
  localparam int          BEAT_W      = `AFF_LANES * `AFF_LANE_W;
  localparam logic [31:0] RAND_SEED   = 32'h5fd57c5a;

  logic                aclk;
  logic                aresetn;
  affine_pkg::beat_t   s_tdata;
  logic                s_tvalid;
  logic                s_tready;
  logic                s_tlast;
  affine_pkg::result_t m_tdata;
  logic                m_tvalid;
  logic                m_tready;
  logic                m_tlast;

  logic [BEAT_W-1:0]   beat_data [$];   // every input beat, in order
  bit                  beat_last [$];
  bit                  beat_is_vec [$];
  int                  beat_idx;        // next beat to present

  logic signed [`AFF_LANE_W-1:0] model_coef [`AFF_ROWS][`AFF_LANES];
  int                  model_row;
  affine_pkg::result_t exp_data_q [$];
  bit                  exp_last_q [$];

  bit                  held;            // output stalled last edge
  affine_pkg::result_t held_data;
  logic                held_last;

  int err_data;
  int err_last;
  int err_order;
  int err_hold;
  int err_reset;
  int cycles;

  affine_stream_top DUT (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic affine_pkg::result_t transform_vector(logic [BEAT_W-1:0] word);
    affine_pkg::result_t res;
    int                  acc;
    int                  lane_val;
    for (int r = 0; r < `AFF_ROWS; r++) begin
      acc = 0;
      for (int c = 0; c < `AFF_LANES; c++) begin
        lane_val = int'($signed(word[c*`AFF_LANE_W +: `AFF_LANE_W]));
        acc = acc + int'(model_coef[r][c]) * lane_val;  // wraps at 32 bits
      end
      res[r] = acc[`AFF_LANE_W-1:0];  // q16 times q0 stays q16
    end
    return res;
  endfunction

  task automatic build_frames();
    int n_vec;
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int r = 0; r < `AFF_ROWS; r++) begin
        beat_data.push_back({$urandom, $urandom});
        beat_last.push_back(($urandom % 4) == 0);  // stray tlast on a row
        beat_is_vec.push_back(1'b0);
      end
      n_vec = 1 + int'($urandom % MAX_VECS);
      for (int v = 0; v < n_vec; v++) begin
        beat_data.push_back({$urandom, $urandom});
        beat_last.push_back(v == n_vec - 1);
        beat_is_vec.push_back(1'b1);
      end
    end
  endtask

  // ----------------------------------------
  // per-edge checks and drive
  // ----------------------------------------
  task automatic verify_hold();
    if (held) begin
      if (m_tvalid !== 1'b1) begin
        $display("error at %0t ns: m_tvalid expected 1, got %b", $time, m_tvalid);
        err_hold++;
      end
      if (m_tdata !== held_data) begin
        $display("error at %0t ns: held m_tdata expected %h, got %h", $time, held_data, m_tdata);
        err_hold++;
      end
      if (m_tlast !== held_last) begin
        $display("error at %0t ns: held m_tlast expected %b, got %b", $time, held_last, m_tlast);
        err_hold++;
      end
    end
  endtask

  task automatic compare_output();
    affine_pkg::result_t exp_data;
    bit                  exp_last;
    if (m_tvalid && m_tready) begin
      if (exp_data_q.size() == 0) begin
        $display("error at %0t ns: output beat with no matching vector beat", $time);
        err_order++;
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        for (int r = 0; r < `AFF_ROWS; r++) begin
          if (m_tdata[r] !== exp_data[r]) begin
            $display("error at %0t ns: m_tdata[%0d] expected %h, got %h",
                     $time, r, exp_data[r], m_tdata[r]);
            err_data++;
          end
        end
        if (m_tlast !== exp_last) begin
          $display("error at %0t ns: m_tlast expected %b, got %b", $time, exp_last, m_tlast);
          err_last++;
        end
      end
    end
  endtask

  task automatic take_input_beat();
    if (s_tvalid && s_tready && beat_idx < beat_data.size()) begin
      if (beat_is_vec[beat_idx]) begin
        exp_data_q.push_back(transform_vector(beat_data[beat_idx]));
        exp_last_q.push_back(beat_last[beat_idx]);
        if (beat_last[beat_idx]) begin
          model_row = 0;  // next frame reloads the matrix
        end
      end else begin
        for (int c = 0; c < `AFF_LANES; c++) begin
          model_coef[model_row][c] = beat_data[beat_idx][c*`AFF_LANE_W +: `AFF_LANE_W];
        end
        model_row++;
      end
      beat_idx++;
    end
  endtask

  task automatic drive_inputs(bit accepted);
    if (s_tvalid && !accepted) begin
      // source keeps the beat until it is taken
    end else if (beat_idx < beat_data.size()) begin
      s_tvalid <= ($urandom % 10) < 7;
      s_tdata  <= beat_data[beat_idx];
      s_tlast  <= beat_last[beat_idx];
    end else begin
      s_tvalid <= 1'b0;
      s_tlast  <= 1'b0;
    end
    m_tready <= ($urandom % 10) < 6;
  endtask

  task automatic run_cycle();
    bit accepted;
    accepted = s_tvalid && s_tready;
    verify_hold();
    compare_output();
    held      = m_tvalid && !m_tready;
    held_data = m_tdata;
    held_last = m_tlast;
    take_input_beat();
    drive_inputs(accepted);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(RAND_SEED));
    aresetn  = 1'b0;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    m_tready = 1'b0;
    beat_idx = 0;
    model_row = 0;
    held     = 1'b0;
    build_frames();
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    if (m_tvalid !== 1'b0) begin
      $display("error at %0t ns: m_tvalid expected 0, got %b", $time, m_tvalid);
      err_reset++;
    end
    if (s_tready !== 1'b1) begin
      $display("error at %0t ns: s_tready expected 1, got %b", $time, s_tready);
      err_reset++;
    end
    while (beat_idx < beat_data.size() || exp_data_q.size() != 0) begin
      @(posedge aclk);
      run_cycle();
    end
    repeat (8) begin  // catch stray outputs
      @(posedge aclk);
      run_cycle();
    end
    if (exp_data_q.size() != 0) begin
      $display("error: %0d expected outputs never appeared", exp_data_q.size());
      err_order++;
    end
    $display("errors: data %0d, last %0d, order %0d, hold %0d, reset %0d",
             err_data, err_last, err_order, err_hold, err_reset);
    if (err_data + err_last + err_order + err_hold + err_reset == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles, %0d beats sent, %0d outputs pending",
             CYCLE_LIMIT, beat_idx, exp_data_q.size());
    $display("test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/affine_pkg.sv
src/frame_loader.sv
src/affine_mac.sv
src/affine_stream_top.sv
testbench/tb_affine_stream.sv
